/* Makefile */
# Verilator build for the PageRank compute unit testbench

VERILATOR = verilator
FLAGS     = --sv --assert --timing
TOP       = pagerank_cu_tb
FILELIST  = pagerank_cu.f
OBJDIR    = obj_dir
PASS_TEXT = Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

/* pagerank_cu.f */
+incdir+verilog
verilog/pagerank_cu_pkg.sv
verilog/sync_fifo.sv
verilog/edge_job_control.sv
verilog/edge_data_control.sv
verilog/read_command_arbiter.sv
verilog/sum_kernel.sv
verilog/pagerank_cu.sv
tb/pagerank_cu_mem.sv
tb/pagerank_cu_tb.sv

/* tb/pagerank_cu_mem.sv */
////////////////////////////////////////////////////////////////////////////
// Memory model for the read bus
// Grants single cycles, answers commands in order with variable latency
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pagerank_cu_settings.svh"

module pagerank_cu_mem (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         read_bus_request,
	output logic                         read_bus_grant,
	input  logic                         read_cmd_valid,
	input  pagerank_cu_pkg::array_kind_t read_cmd_kind,
	input  logic [`PRC_INDEX_W-1:0]      read_cmd_address,
	output logic                         read_resp_valid,
	output pagerank_cu_pkg::array_kind_t read_resp_kind,
	output logic [`PRC_DATA_W-1:0]       read_resp_data,
	input  logic [2:0]                   latency_pick,
	input  logic [1:0]                   gap_pick
);

	int              cycle;
	int              last_due;
	int              gap;
	int              due;
	int              address;
	logic            waiting;
	logic            grant_next;
	logic            resp_next;
	logic [32:0]     word;
	int              due_q[$];
	logic [32:0]     resp_q[$];

	initial begin
		read_bus_grant  = 1'b0;
		read_resp_valid = 1'b0;
		read_resp_kind  = pagerank_cu_pkg::EDGE_ARRAY_DEST;
		read_resp_data  = '0;
		word            = '0;
	end

	// Inputs sampled on the edge, outputs driven 1 ns later
	always @(posedge clock) begin
		grant_next = 1'b0;
		resp_next  = 1'b0;
		if (!rstn) begin
			cycle    = 0;
			last_due = 0;
			gap      = 0;
			waiting  = 1'b0;
			due_q.delete();
			resp_q.delete();
		end else begin
			cycle++;
			if (read_cmd_valid) begin
				waiting = 1'b0;
				// Request lags the pop by a cycle
				gap     = int'(gap_pick) + 1;
				due     = cycle + int'(latency_pick) % 6 + 1;
				// Keep responses in command order
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				address  = int'(read_cmd_address);
				if (read_cmd_kind == pagerank_cu_pkg::EDGE_ARRAY_DEST) begin
					word = {1'b0, 32'((address * 7 + 3) % 256)};
				end else begin
					word = {1'b1, 32'(address * 13 + 5)};
				end
				due_q.push_back(due);
				resp_q.push_back(word);
			end else if (!waiting && gap > 0) begin
				gap--;
			end
			// One grant at a time, only on a request
			if (!waiting && gap == 0 && read_bus_request) begin
				grant_next = 1'b1;
				waiting    = 1'b1;
			end
			if (due_q.size() > 0 && due_q[0] <= cycle) begin
				resp_next = 1'b1;
				word      = resp_q.pop_front();
				due       = due_q.pop_front();
			end
		end
		#1;
		read_bus_grant  = grant_next;
		read_resp_valid = resp_next;
		read_resp_kind  = pagerank_cu_pkg::array_kind_t'(word[32]);
		read_resp_data  = word[31:0];
	end

endmodule

/* tb/pagerank_cu_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the PageRank compute unit
// Vertex stimulus, bus noise, reference sums, checker and timeout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pagerank_cu_settings.svh"

module pagerank_cu_tb;

	localparam int NUM_VERTICES   = 40;
	localparam int MAX_UNFINISHED = 8;
	localparam int HOLD_START     = 400;
	localparam int TIMEOUT_CYCLES = 200 * NUM_VERTICES + 1000;

	logic                         clock;
	logic                         rstn;
	logic                         vertex_valid;
	logic [`PRC_VERTEX_W-1:0]     vertex_id;
	logic [`PRC_INDEX_W-1:0]      vertex_edge_start;
	logic [`PRC_DEGREE_W-1:0]     vertex_degree;
	logic                         vertex_request;
	logic                         read_bus_request;
	logic                         read_bus_grant;
	logic                         read_buffer_alfull;
	logic                         read_cmd_valid;
	pagerank_cu_pkg::array_kind_t read_cmd_kind;
	logic [`PRC_INDEX_W-1:0]      read_cmd_address;
	logic                         read_resp_valid;
	pagerank_cu_pkg::array_kind_t read_resp_kind;
	logic [`PRC_DATA_W-1:0]       read_resp_data;
	logic                         write_valid;
	logic [`PRC_VERTEX_W-1:0]     write_vertex_id;
	logic [`PRC_DATA_W-1:0]       write_sum;
	logic [`PRC_VERTEX_W-1:0]     vertex_count;
	logic [`PRC_DEGREE_W-1:0]     edge_count;
	logic [2:0]                   latency_pick;
	logic [1:0]                   gap_pick;

	logic [31:0]              lfsr = 32'ha487d0b8;
	int                       sent = 0;
	int                       done_count = 0;
	int                       mismatch_count = 0;
	int                       other_count = 0;
	int                       edge_cmds = 0;
	int                       data_cmds = 0;
	int                       alfull_run = 0;
	int                       cycle_count = 0;
	int                       noise_cycle = 0;
	int                       burst_left = 0;
	int                       total_degree = 0;
	int                       degree_of [NUM_VERTICES];
	int                       start_of [NUM_VERTICES];
	int                       pause_of [NUM_VERTICES];
	logic [`PRC_VERTEX_W-1:0] exp_id_q[$];
	logic [31:0]              exp_sum_q[$];
	int                       edge_addr_q[$];

	pagerank_cu dut0 (.*);

	pagerank_cu_mem mem0 (
		.clock             (clock),
		.rstn              (rstn),
		.read_bus_request  (read_bus_request),
		.read_bus_grant    (read_bus_grant),
		.read_cmd_valid    (read_cmd_valid),
		.read_cmd_kind     (read_cmd_kind),
		.read_cmd_address  (read_cmd_address),
		.read_resp_valid   (read_resp_valid),
		.read_resp_kind    (read_resp_kind),
		.read_resp_data    (read_resp_data),
		.latency_pick      (latency_pick),
		.gap_pick          (gap_pick)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR, one step per bit
	function automatic logic next_bit();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 32'h80200003;
		end
		return out;
	endfunction

	function automatic int random_bits(input int count);
		int value;
		value = 0;
		for (int k = 0; k < count; k++) begin
			value = (value << 1) | int'(next_bit());
		end
		return value;
	endfunction

	// Edge word at index a is (7a+3) mod 256, rank of v is 13v+5
	function automatic logic [31:0] reference_sum(input int start, input int degree);
		logic [31:0] sum;
		int          neighbor;
		sum = '0;
		for (int k = 0; k < degree; k++) begin
			neighbor = ((start + k) * 7 + 3) % 256;
			sum      = sum + 32'(neighbor * 13 + 5);
		end
		return sum;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			mismatch_count++;
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int i;
		int j;
		rstn              = 1'b0;
		vertex_valid      = 1'b0;
		vertex_id         = '0;
		vertex_edge_start = '0;
		vertex_degree     = '0;
		read_buffer_alfull = 1'b0;
		latency_pick      = '0;
		gap_pick          = '0;
		// Vertex 5 always has no edges
		for (i = 0; i < NUM_VERTICES; i++) begin
			degree_of[i] = (i == 5) ? 0 : random_bits(3);
			start_of[i]  = random_bits(12);
			pause_of[i]  = random_bits(2);
			exp_id_q.push_back(16'(i * 3 + 1));
			exp_sum_q.push_back(reference_sum(start_of[i], degree_of[i]));
			for (j = 0; j < degree_of[i]; j++) begin
				edge_addr_q.push_back(start_of[i] + j);
			end
			total_degree += degree_of[i];
		end
		repeat (16) @(posedge clock);
		#1;
		rstn = 1'b1;
		repeat (2) @(posedge clock);
		if (!vertex_request) begin
			other_count++;
			$display("vertex_request is low while the vertex queue is empty");
		end
		for (i = 0; i < NUM_VERTICES; i++) begin
			wait (sent - done_count < MAX_UNFINISHED);
			repeat (pause_of[i]) @(posedge clock);
			@(posedge clock);
			#1;
			vertex_valid      = 1'b1;
			vertex_id         = 16'(i * 3 + 1);
			vertex_edge_start = 16'(start_of[i]);
			vertex_degree     = 16'(degree_of[i]);
			sent++;
			@(posedge clock);
			#1;
			vertex_valid = 1'b0;
		end
		wait (done_count == NUM_VERTICES);
		repeat (2) @(posedge clock);
		check_value("vertex_count", 32'(vertex_count), 32'(NUM_VERTICES));
		check_value("edge_count", 32'(edge_count), 32'(total_degree));
		check_value("edge read commands", 32'(edge_cmds), 32'(total_degree));
		check_value("graph-data read commands", 32'(data_cmds), 32'(total_degree));
		$display("%0d mismatches, %0d other errors", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Response latency, grant gaps, short alfull bursts and one long hold
	always @(posedge clock) begin
		if (rstn) begin
			#1;
			noise_cycle++;
			latency_pick = 3'(random_bits(3));
			gap_pick     = 2'(random_bits(2));
			if (noise_cycle == HOLD_START) begin
				burst_left = 30;
			end else if (burst_left == 0 && random_bits(5) == 0) begin
				burst_left = 1 + random_bits(3);
			end
			if (burst_left > 0) begin
				read_buffer_alfull = 1'b1;
				burst_left--;
			end else begin
				read_buffer_alfull = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checker and timeout
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		if (rstn) begin
			if (write_valid) begin
				if (exp_id_q.size() == 0) begin
					other_count++;
					$display("write for vertex %0d at %0t with no vertex outstanding",
						write_vertex_id, $time);
				end else begin
					check_value("write_vertex_id", 32'(write_vertex_id), 32'(exp_id_q.pop_front()));
					check_value("write_sum", write_sum, exp_sum_q.pop_front());
				end
				done_count++;
			end
			if (read_cmd_valid) begin
				// A request raised before alfull rose may still be granted
				if (read_buffer_alfull && alfull_run >= 4) begin
					other_count++;
					$display("read command at %0t while the read buffer was almost full", $time);
				end
				if (read_cmd_kind == pagerank_cu_pkg::EDGE_ARRAY_DEST) begin
					edge_cmds++;
					if (edge_addr_q.size() == 0) begin
						other_count++;
						$display("edge read at %0t beyond the last vertex edge", $time);
					end else begin
						check_value("edge read address", 32'(read_cmd_address),
							32'(edge_addr_q.pop_front()));
					end
				end else begin
					data_cmds++;
				end
			end
			if (read_buffer_alfull) begin
				alfull_run++;
			end else begin
				alfull_run = 0;
			end
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			other_count++;
			$display("timeout after %0d cycles with %0d of %0d vertices written",
				cycle_count, done_count, NUM_VERTICES);
			$display("%0d mismatches, %0d other errors", mismatch_count, other_count);
			$display("Test failed");
			$finish;
		end
	end

endmodule

/* verilog/edge_data_control.sv */
////////////////////////////////////////////////////////////////////////////
// Edge data control
// Queues neighbor ids and presents each as a graph-data read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pagerank_cu_settings.svh"

module edge_data_control (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     neighbor_valid,
	input  logic [`PRC_VERTEX_W-1:0] neighbor_id,
	output logic                     req,
	input  logic                     take,
	output logic [`PRC_INDEX_W-1:0]  cmd_address,
	output logic                     neighbor_taken
);

	logic [`PRC_VERTEX_W-1:0] head_id;
	logic                     queue_empty;

	// Sized to the edge-read limit, so it cannot overflow
	sync_fifo #(
		.WIDTH     (`PRC_VERTEX_W),
		.DEPTH     (`PRC_MAX_OUTSTANDING),
		.ALFULL_GAP(1)
	) neighbor_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (neighbor_valid),
		.data_in (neighbor_id),
		.pop     (take),
		.data_out(head_id),
		.empty   (queue_empty),
		.full    (),
		.alfull  ()
	);

	// A vertex's rank lives at its own id in the graph data
	assign req         = !queue_empty;
	assign cmd_address = `PRC_INDEX_W'(head_id);

	// One credit back to the edge side per neighbor taken
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			neighbor_taken <= 1'b0;
		end else begin
			neighbor_taken <= take;
		end
	end

	take_from_empty: assert property (@(posedge clock) disable iff (!rstn)
		take |-> !queue_empty);

endmodule

/* verilog/edge_job_control.sv */
////////////////////////////////////////////////////////////////////////////
// Edge job control
// Pops one vertex at a time, issues its edge-array reads and
// forwards the returned neighbor ids
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pagerank_cu_settings.svh"

module edge_job_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        vertex_empty,
	output logic                        vertex_pop,
	input  logic [`PRC_VERTEX_W-1:0]    vertex_id,
	input  logic [`PRC_INDEX_W-1:0]     vertex_edge_start,
	input  logic [`PRC_DEGREE_W-1:0]    vertex_degree,
	input  logic                        edge_resp_valid,
	input  pagerank_cu_pkg::read_word_u edge_resp_data,
	output logic                        req,
	input  logic                        take,
	output logic [`PRC_INDEX_W-1:0]     cmd_address,
	output logic                        neighbor_valid,
	output logic [`PRC_VERTEX_W-1:0]    neighbor_id,
	input  logic                        neighbor_taken,
	output logic                        vertex_start,
	output logic [`PRC_VERTEX_W-1:0]    start_id,
	output logic [`PRC_DEGREE_W-1:0]    start_degree,
	input  logic                        vertex_done
);

	localparam int OUT_W = $clog2(`PRC_MAX_OUTSTANDING + 1);
	localparam logic [OUT_W-1:0] OUT_LIMIT = OUT_W'(`PRC_MAX_OUTSTANDING);

	logic                     busy;
	logic [`PRC_INDEX_W-1:0]  edge_start;
	logic [`PRC_DEGREE_W-1:0] issued;
	logic [OUT_W-1:0]         outstanding;

	assign vertex_pop = !busy && !vertex_empty;

	// Edge reads at consecutive indices, throttled by reads in flight
	assign req         = busy && (issued != start_degree) && (outstanding < OUT_LIMIT);
	assign cmd_address = edge_start + `PRC_INDEX_W'(issued);

	// Current vertex
	always_ff @(posedge clock) begin
		if (vertex_pop) begin
			start_id     <= vertex_id;
			edge_start   <= vertex_edge_start;
			start_degree <= vertex_degree;
		end
		if (edge_resp_valid) begin
			neighbor_id <= edge_resp_data.neighbor.id;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy           <= 1'b0;
			vertex_start   <= 1'b0;
			issued         <= '0;
			outstanding    <= '0;
			neighbor_valid <= 1'b0;
		end else begin
			vertex_start   <= vertex_pop;
			neighbor_valid <= edge_resp_valid;
			if (vertex_pop) begin
				busy   <= 1'b1;
				issued <= '0;
			end else begin
				if (vertex_done) begin
					busy <= 1'b0;
				end
				if (take) begin
					issued <= issued + 1'b1;
				end
			end
			// Freed once the data side has turned the neighbor into a command
			case ({take, neighbor_taken})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	done_while_idle: assert property (@(posedge clock) disable iff (!rstn)
		vertex_done |-> busy);

endmodule

/* verilog/pagerank_cu.sv */
////////////////////////////////////////////////////////////////////////////
// PageRank pull-sum compute unit, top level
// Vertex queue, response routing, command FIFO and read bus handshake
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pagerank_cu_settings.svh"

module pagerank_cu (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         vertex_valid,
	input  logic [`PRC_VERTEX_W-1:0]     vertex_id,
	input  logic [`PRC_INDEX_W-1:0]      vertex_edge_start,
	input  logic [`PRC_DEGREE_W-1:0]     vertex_degree,
	output logic                         vertex_request,
	output logic                         read_bus_request,
	input  logic                         read_bus_grant,
	input  logic                         read_buffer_alfull,
	output logic                         read_cmd_valid,
	output pagerank_cu_pkg::array_kind_t read_cmd_kind,
	output logic [`PRC_INDEX_W-1:0]      read_cmd_address,
	input  logic                         read_resp_valid,
	input  pagerank_cu_pkg::array_kind_t read_resp_kind,
	input  logic [`PRC_DATA_W-1:0]       read_resp_data,
	output logic                         write_valid,
	output logic [`PRC_VERTEX_W-1:0]     write_vertex_id,
	output logic [`PRC_DATA_W-1:0]       write_sum,
	output logic [`PRC_VERTEX_W-1:0]     vertex_count,
	output logic [`PRC_DEGREE_W-1:0]     edge_count
);

	localparam int VQ_W  = `PRC_VERTEX_W + `PRC_INDEX_W + `PRC_DEGREE_W;
	localparam int CMD_W = 1 + `PRC_INDEX_W;

	logic                         vq_empty;
	logic                         vq_pop;
	logic [VQ_W-1:0]              vq_head;
	logic                         edge_req;
	logic                         edge_take;
	logic [`PRC_INDEX_W-1:0]      edge_address;
	logic                         data_req;
	logic                         data_take;
	logic [`PRC_INDEX_W-1:0]      data_address;
	logic                         cmd_push;
	pagerank_cu_pkg::array_kind_t push_kind;
	logic [`PRC_INDEX_W-1:0]      push_address;
	logic [CMD_W-1:0]             cmd_head;
	logic                         cmd_empty;
	logic                         cmd_alfull;
	logic                         grant_q;
	logic                         edge_resp_valid;
	logic                         rank_valid;
	pagerank_cu_pkg::read_word_u  resp_word;
	logic                         neighbor_valid;
	logic [`PRC_VERTEX_W-1:0]     neighbor_id;
	logic                         neighbor_taken;
	logic                         vertex_start;
	logic [`PRC_VERTEX_W-1:0]     start_id;
	logic [`PRC_DEGREE_W-1:0]     start_degree;
	logic                         vertex_done;

	////////////////////////////////////////////////////////////////////////////
	// Vertex queue
	////////////////////////////////////////////////////////////////////////////

	sync_fifo #(.WIDTH(VQ_W), .DEPTH(`PRC_VERTEX_DEPTH), .ALFULL_GAP(2)) vertex_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_valid),
		.data_in ({vertex_id, vertex_edge_start, vertex_degree}),
		.pop     (vq_pop),
		.data_out(vq_head),
		.empty   (vq_empty),
		.full    (),
		.alfull  ()
	);

	////////////////////////////////////////////////////////////////////////////
	// Engines
	////////////////////////////////////////////////////////////////////////////

	edge_job_control edge_job (
		.clock            (clock),
		.rstn             (rstn),
		.vertex_empty     (vq_empty),
		.vertex_pop       (vq_pop),
		.vertex_id        (vq_head[VQ_W-1 -: `PRC_VERTEX_W]),
		.vertex_edge_start(vq_head[`PRC_DEGREE_W +: `PRC_INDEX_W]),
		.vertex_degree    (vq_head[`PRC_DEGREE_W-1:0]),
		.edge_resp_valid  (edge_resp_valid),
		.edge_resp_data   (resp_word),
		.req              (edge_req),
		.take             (edge_take),
		.cmd_address      (edge_address),
		.neighbor_valid   (neighbor_valid),
		.neighbor_id      (neighbor_id),
		.neighbor_taken   (neighbor_taken),
		.vertex_start     (vertex_start),
		.start_id         (start_id),
		.start_degree     (start_degree),
		.vertex_done      (vertex_done)
	);

	edge_data_control edge_data (
		.clock         (clock),
		.rstn          (rstn),
		.neighbor_valid(neighbor_valid),
		.neighbor_id   (neighbor_id),
		.req           (data_req),
		.take          (data_take),
		.cmd_address   (data_address),
		.neighbor_taken(neighbor_taken)
	);

	sum_kernel sum (
		.clock          (clock),
		.rstn           (rstn),
		.vertex_start   (vertex_start),
		.start_id       (start_id),
		.start_degree   (start_degree),
		.rank_valid     (rank_valid),
		.rank_data      (resp_word),
		.vertex_done    (vertex_done),
		.write_valid    (write_valid),
		.write_vertex_id(write_vertex_id),
		.write_sum      (write_sum),
		.vertex_count   (vertex_count),
		.edge_count     (edge_count)
	);

	////////////////////////////////////////////////////////////////////////////
	// Read command path
	////////////////////////////////////////////////////////////////////////////

	read_command_arbiter arbiter (
		.clock       (clock),
		.rstn        (rstn),
		.edge_req    (edge_req),
		.edge_address(edge_address),
		.edge_take   (edge_take),
		.data_req    (data_req),
		.data_address(data_address),
		.data_take   (data_take),
		.cmd_alfull  (cmd_alfull),
		.push        (cmd_push),
		.push_kind   (push_kind),
		.push_address(push_address)
	);

	// Gap of two covers the push still in flight behind a take
	sync_fifo #(.WIDTH(CMD_W), .DEPTH(`PRC_CMD_DEPTH), .ALFULL_GAP(2)) cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_push),
		.data_in ({push_kind, push_address}),
		.pop     (grant_q),
		.data_out(cmd_head),
		.empty   (cmd_empty),
		.full    (),
		.alfull  (cmd_alfull)
	);

	// Registered bus handshake, response routing by kind
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_q          <= 1'b0;
			read_bus_request <= 1'b0;
			read_cmd_valid   <= 1'b0;
			vertex_request   <= 1'b0;
			edge_resp_valid  <= 1'b0;
			rank_valid       <= 1'b0;
		end else begin
			grant_q          <= read_bus_grant;
			read_bus_request <= !cmd_empty && !read_buffer_alfull;
			read_cmd_valid   <= grant_q && !cmd_empty;
			vertex_request   <= vq_empty;
			edge_resp_valid  <= read_resp_valid
				&& (read_resp_kind == pagerank_cu_pkg::EDGE_ARRAY_DEST);
			rank_valid       <= read_resp_valid
				&& (read_resp_kind == pagerank_cu_pkg::READ_GRAPH_DATA);
		end
	end

	always_ff @(posedge clock) begin
		if (grant_q) begin
			read_cmd_kind    <= pagerank_cu_pkg::array_kind_t'(cmd_head[CMD_W-1]);
			read_cmd_address <= cmd_head[`PRC_INDEX_W-1:0];
		end
		if (read_resp_valid) begin
			resp_word <= read_resp_data;
		end
	end

	// A grant only follows a request, so a command is always waiting
	grant_finds_cmd: assert property (@(posedge clock) disable iff (!rstn)
		grant_q |-> !cmd_empty);

endmodule

/* verilog/pagerank_cu_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types of the PageRank compute unit
// Array kind carried on read commands and responses
// Read response word with its two decodings
////////////////////////////////////////////////////////////////////////////

`include "pagerank_cu_settings.svh"

package pagerank_cu_pkg;

	// Target array of a read, echoed back on its response
	typedef enum logic {
		EDGE_ARRAY_DEST = 1'b0,
		READ_GRAPH_DATA = 1'b1
	} array_kind_t;

	// Edge-array words hold a neighbor id, graph-data words hold a rank
	typedef union packed {
		struct packed {
			logic [`PRC_DATA_W-`PRC_VERTEX_W-1:0] upper;
			logic [`PRC_VERTEX_W-1:0]             id;
		} neighbor;
		logic [`PRC_DATA_W-1:0] rank;
	} read_word_u;

endpackage

/* verilog/pagerank_cu_settings.svh */
////////////////////////////////////////////////////////////////////////////
// Widths, queue depths and the read limit of the PageRank compute unit
////////////////////////////////////////////////////////////////////////////

`ifndef PAGERANK_CU_SETTINGS_SVH
`define PAGERANK_CU_SETTINGS_SVH

// Field widths
`define PRC_VERTEX_W        16
`define PRC_INDEX_W         16
`define PRC_DEGREE_W        16
`define PRC_DATA_W          32

// Queue depths, all powers of two
`define PRC_VERTEX_DEPTH    16
`define PRC_CMD_DEPTH       8
// Edge reads in flight, also the neighbor queue depth
`define PRC_MAX_OUTSTANDING 8

`endif

/* verilog/read_command_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter for the edge and data read commands
// Winner is registered into a command FIFO push
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pagerank_cu_settings.svh"

module read_command_arbiter (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         edge_req,
	input  logic [`PRC_INDEX_W-1:0]      edge_address,
	output logic                         edge_take,
	input  logic                         data_req,
	input  logic [`PRC_INDEX_W-1:0]      data_address,
	output logic                         data_take,
	input  logic                         cmd_alfull,
	output logic                         push,
	output pagerank_cu_pkg::array_kind_t push_kind,
	output logic [`PRC_INDEX_W-1:0]      push_address
);

	logic last_data;
	logic edge_win;
	logic data_win;

	// On a tie the side that lost last time goes first
	assign edge_win  = edge_req && (!data_req || last_data);
	assign data_win  = data_req && (!edge_req || !last_data);
	assign edge_take = edge_win && !cmd_alfull;
	assign data_take = data_win && !cmd_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			push      <= 1'b0;
			last_data <= 1'b0;
		end else begin
			push <= edge_take || data_take;
			if (edge_take || data_take) begin
				last_data <= data_take;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (data_take) begin
			push_kind    <= pagerank_cu_pkg::READ_GRAPH_DATA;
			push_address <= data_address;
		end else if (edge_take) begin
			push_kind    <= pagerank_cu_pkg::EDGE_ARRAY_DEST;
			push_address <= edge_address;
		end
	end

	one_take: assert property (@(posedge clock) disable iff (!rstn)
		!(edge_take && data_take));

endmodule

/* verilog/sum_kernel.sv */
////////////////////////////////////////////////////////////////////////////
// Sum kernel
// Adds the neighbor ranks of the current vertex, emits the write
// pulse and keeps the completed vertex and edge counts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pagerank_cu_settings.svh"

module sum_kernel (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        vertex_start,
	input  logic [`PRC_VERTEX_W-1:0]    start_id,
	input  logic [`PRC_DEGREE_W-1:0]    start_degree,
	input  logic                        rank_valid,
	input  pagerank_cu_pkg::read_word_u rank_data,
	output logic                        vertex_done,
	output logic                        write_valid,
	output logic [`PRC_VERTEX_W-1:0]    write_vertex_id,
	output logic [`PRC_DATA_W-1:0]      write_sum,
	output logic [`PRC_VERTEX_W-1:0]    vertex_count,
	output logic [`PRC_DEGREE_W-1:0]    edge_count
);

	logic                     active;
	logic                     finish;
	logic [`PRC_DEGREE_W-1:0] degree;
	logic [`PRC_DEGREE_W-1:0] rank_count;

	// Complete once every rank is in; degree zero finishes at once
	assign finish      = active && (rank_count == degree);
	assign vertex_done = finish;
	assign write_valid = finish;

	// Sum wraps at the word width
	always_ff @(posedge clock) begin
		if (vertex_start) begin
			write_vertex_id <= start_id;
			degree          <= start_degree;
			write_sum       <= '0;
		end else if (rank_valid) begin
			write_sum <= write_sum + rank_data.rank;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active       <= 1'b0;
			rank_count   <= '0;
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			if (vertex_start) begin
				active     <= 1'b1;
				rank_count <= '0;
			end else if (finish) begin
				active <= 1'b0;
			end else if (rank_valid) begin
				rank_count <= rank_count + 1'b1;
			end
			if (finish) begin
				vertex_count <= vertex_count + 1'b1;
				edge_count   <= edge_count + degree;
			end
		end
	end

	// More ranks than edges means a response was misrouted
	rank_overrun: assert property (@(posedge clock) disable iff (!rstn)
		rank_valid |-> (active && (rank_count < degree)));

endmodule

/* verilog/sync_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Synchronous FIFO, first-word fall-through, with almost-full flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH      = 8,
	parameter int DEPTH      = 8,
	parameter int ALFULL_GAP = 2
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full,
	output logic             alfull
);

	// Pointers wrap on their own since DEPTH is a power of two
	localparam int PTR_W = $clog2(DEPTH);
	localparam logic [PTR_W:0] FULL_COUNT   = (PTR_W + 1)'(DEPTH);
	localparam logic [PTR_W:0] ALFULL_COUNT = (PTR_W + 1)'(DEPTH - ALFULL_GAP);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// Head word is visible before it is popped
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign empty  = (count == '0);
	assign full   = (count == FULL_COUNT);
	assign alfull = (count >= ALFULL_COUNT);

	// Producers hold off on full
	push_while_full: assert property (@(posedge clock) disable iff (!rstn)
		!(push && full));

endmodule
